// File: tb.f
input_router_pkg.sv
input_router_controller.sv
address_generator.sv
row_router.sv
tile_reader.sv
row_data_collector.sv
input_router_top.sv
tb_clock.sv
input_router_chk.sv
input_router_tb.sv

// File: input_router_tb.sv
`timescale 1ns/1ns

module input_router_tb;

    localparam int RUNS = 20;
    localparam int MEM_WORDS = 2 ** input_router_pkg::ADDR_WIDTH;
    // One extra batch per run covers the aborted start
    localparam int MAX_BATCHES = 9 + 1;
    // Full tile scan plus generation, stall and data out
    localparam int BATCH_CYCLES = 300;
    localparam int TIMEOUT_CYCLES = RUNS * (MEM_WORDS + MAX_BATCHES * BATCH_CYCLES + 50);

    logic clk;
    logic nrst;
    logic en;
    logic reg_clear;
    logic data_out_en;
    input_router_pkg::router_cfg_t cfg;
    input_router_pkg::mem_write_t mem_wr;
    logic data_out_ready;
    logic done;
    input_router_pkg::out_word_t out_word;

    integer seed = 44354;
    int cycle_count = 0;
    int error_count = 0;
    logic [input_router_pkg::DATA_WIDTH-1:0] model_mem [MEM_WORDS];
    input_router_pkg::out_word_t expected_q [$];

    tb_clock clock_inst (.o_clk(clk));

    input_router_top input_router_top_inst (
        .i_clk(clk), .i_nrst(nrst), .i_en(en), .i_reg_clear(reg_clear), .i_cfg(cfg),
        .i_mem_wr(mem_wr), .i_data_out_en(data_out_en),
        .o_data_out_ready(data_out_ready), .o_done(done), .o_out(out_word)
    );

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Watchdog and bound assertion monitor
    always @(posedge clk) begin
        cycle_count++;
        if (input_router_top_inst.chk_inst.fail_count != 0) begin
            $display("An assertion on the router top level failed at %0t ns", $time);
            $display("ERRORS FOUND");
            $fatal(1, "assertion failure");
        end else if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    task automatic load_memory();
        for (int a = 0; a < MEM_WORDS; a++) begin
            model_mem[a] = $random(seed);
            @(posedge clk);
            mem_wr <= '{en: 1'b1, addr: a[input_router_pkg::ADDR_WIDTH-1:0], data: model_mem[a]};
        end
        @(posedge clk);
        mem_wr <= '0;
    endtask

    // Coordinates with y inner, x outer, row id cycling per batch
    task automatic build_model(input input_router_pkg::router_cfg_t c);
        int span;
        int idx;
        input_router_pkg::out_word_t w;
        span = c.o_size * c.stride - c.stride;
        idx = 0;
        expected_q.delete();
        for (int x = 0; x <= span; x += c.stride) begin
            for (int y = 0; y <= span; y += c.stride) begin
                w.valid = 1'b1;
                w.row_id = idx % input_router_pkg::ROW_COUNT;
                w.coord.x = x;
                w.coord.y = y;
                w.data = model_mem[(c.start_addr + y * c.o_size * c.stride + x) % MEM_WORDS];
                expected_q.push_back(w);
                idx++;
            end
        end
    endtask

    task automatic run_batches();
        int batch_size;
        int stall;
        int got;
        input_router_pkg::out_word_t exp_w;
        while (expected_q.size() > 0) begin
            batch_size = (expected_q.size() < input_router_pkg::ROW_COUNT) ?
                         expected_q.size() : input_router_pkg::ROW_COUNT;
            @(negedge clk);
            while (!data_out_ready) begin
                check_value(out_word.valid, 1'b0, "word before data out ready");
                @(negedge clk);
            end
            // Upper level holds off for a while
            stall = $unsigned($random(seed)) % 8;
            repeat (stall) begin
                @(negedge clk);
                check_value(out_word.valid, 1'b0, "word while data out disabled");
                check_value(data_out_ready, 1'b1, "ready during data out stall");
            end
            @(posedge clk);
            data_out_en <= 1'b1;
            got = 0;
            @(negedge clk);
            while (data_out_ready) begin
                if (out_word.valid) begin
                    check_value(got < batch_size, 1'b1, "word count within batch");
                    exp_w = expected_q.pop_front();
                    check_value(out_word, exp_w, "delivered word");
                    got++;
                end
                @(negedge clk);
            end
            check_value(got, batch_size, "words in batch");
            check_value(done, expected_q.size() == 0, "done after batch");
            @(posedge clk);
            data_out_en <= 1'b0;
        end
    endtask

    // Clear once the first batch is compared, the restart begins at (0, 0)
    task automatic abort_and_restart();
        @(negedge clk);
        while (!data_out_ready) begin
            check_value(out_word.valid, 1'b0, "word before aborted data out");
            @(negedge clk);
        end
        @(posedge clk);
        reg_clear <= 1'b1;
        @(posedge clk);
        reg_clear <= 1'b0;
        @(negedge clk);
        check_value(data_out_ready, 1'b0, "ready after mid-run clear");
        check_value(done, 1'b0, "done after mid-run clear");
        @(posedge clk);
        en <= 1'b1;
        @(posedge clk);
        en <= 1'b0;
    endtask

    // A new start request must be ignored while done is set
    task automatic check_quiet_after_done();
        @(posedge clk);
        en <= 1'b1;
        @(posedge clk);
        en <= 1'b0;
        repeat (20) begin
            @(negedge clk);
            check_value(out_word.valid, 1'b0, "word after done");
            check_value(done, 1'b1, "done held until clear");
            check_value(data_out_ready, 1'b0, "ready after done");
        end
    endtask

    initial begin
        input_router_pkg::router_cfg_t new_cfg;
        nrst = 1'b0;
        en = 1'b0;
        reg_clear = 1'b0;
        data_out_en = 1'b0;
        cfg = '0;
        mem_wr = '0;
        repeat (5) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        check_value(done, 1'b0, "done after reset");
        check_value(data_out_ready, 1'b0, "ready after reset");
        check_value(out_word.valid, 1'b0, "valid after reset");
        for (int run = 0; run < RUNS; run++) begin
            new_cfg.o_size = 1 + $unsigned($random(seed)) % 6;
            new_cfg.stride = 1 + $unsigned($random(seed)) % 3;
            new_cfg.start_addr = $random(seed);
            @(posedge clk);
            reg_clear <= 1'b1;
            @(posedge clk);
            reg_clear <= 1'b0;
            cfg <= new_cfg;
            load_memory();
            @(negedge clk);
            check_value(done, 1'b0, "done after clear");
            build_model(new_cfg);
            @(posedge clk);
            en <= 1'b1;
            @(posedge clk);
            en <= 1'b0;
            if (run % 2 == 1) begin
                abort_and_restart();
            end
            run_batches();
            check_quiet_after_done();
        end
        if (error_count == 0 && input_router_top_inst.chk_inst.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: input_router_chk.sv
`timescale 1ns/1ns

module input_router_chk (
    input logic                        i_clk,
    input logic                        i_nrst,
    input logic                        i_reg_clear,
    input logic                        i_ac_en,
    input logic                        i_pop_en,
    input logic                        i_data_out_ready,
    input logic                        i_done,
    input input_router_pkg::out_word_t i_out
);

    // Number of failed assertions, watched by the testbench
    int fail_count = 0;

    // Comparison and data out never overlap
    a_cmp_pop_exclusive: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(i_ac_en && i_pop_en))
        else begin
            $error("compare enable and pop enable are high together");
            fail_count++;
        end

    a_valid_in_data_out: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_out.valid |-> i_data_out_ready)
        else begin
            $error("output word valid while data out is not ready");
            fail_count++;
        end

    // Done is sticky until the next clear
    a_done_held: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_done && !i_reg_clear |=> i_done)
        else begin
            $error("done dropped without a clear");
            fail_count++;
        end

endmodule

bind input_router_top input_router_chk chk_inst (
    .i_clk(i_clk), .i_nrst(i_nrst), .i_reg_clear(i_reg_clear), .i_ac_en(ac_en),
    .i_pop_en(pop_en), .i_data_out_ready(o_data_out_ready), .i_done(o_done), .i_out(o_out)
);

// File: tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic o_clk
);

    // 8 ns period
    localparam int HALF_PERIOD = 4;

    initial begin
        o_clk = 1'b0;
        forever begin
            #HALF_PERIOD o_clk = ~o_clk;
        end
    end

endmodule

// File: input_router_top.sv
`timescale 1ns/1ns

module input_router_top (
    input  logic                            i_clk,
    input  logic                            i_nrst,
    input  logic                            i_en,
    input  logic                            i_reg_clear,
    input  input_router_pkg::router_cfg_t   i_cfg,
    input  input_router_pkg::mem_write_t    i_mem_wr,
    input  logic                            i_data_out_en,
    output logic                            o_data_out_ready,
    output logic                            o_done,
    output input_router_pkg::out_word_t     o_out
);

    input_router_pkg::coord_t                  coord;
    logic [input_router_pkg::ROW_ID_WIDTH-1:0] row_id;
    logic                                      ag_en;
    logic                                      ac_en;
    logic                                      tile_read_en;
    logic                                      pop_en;
    logic                                      reg_clear;
    logic                                      addr_empty;
    logic                                      data_empty;
    logic [input_router_pkg::ROW_COUNT-1:0]    push;
    logic [input_router_pkg::ROW_COUNT-1:0]    pop;
    logic [input_router_pkg::ROW_COUNT-1:0]    addr_empty_vec;
    logic [input_router_pkg::ROW_COUNT-1:0]    data_empty_vec;
    input_router_pkg::addr_req_t               req;
    input_router_pkg::tile_word_t              tile;
    input_router_pkg::out_word_t               row_data [input_router_pkg::ROW_COUNT];

    input_router_controller controller_inst (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_en(i_en), .i_reg_clear(i_reg_clear),
        .i_data_out_en(i_data_out_en), .i_cfg(i_cfg),
        .i_addr_empty(addr_empty), .i_data_empty(data_empty),
        .o_coord(coord), .o_row_id(row_id), .o_ag_en(ag_en), .o_ac_en(ac_en),
        .o_tile_read_en(tile_read_en), .o_pop_en(pop_en), .o_done(o_done),
        .o_reg_clear(reg_clear), .o_data_out_ready(o_data_out_ready)
    );

    address_generator address_generator_inst (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_ag_en(ag_en), .i_coord(coord),
        .i_row_id(row_id), .i_cfg(i_cfg), .o_push(push), .o_req(req)
    );

    tile_reader tile_reader_inst (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_mem_wr(i_mem_wr),
        .i_tile_read_en(tile_read_en), .o_tile(tile)
    );

    for (genvar r = 0; r < input_router_pkg::ROW_COUNT; r++) begin : g_row
        row_router row_router_inst (
            .i_clk(i_clk), .i_nrst(i_nrst), .i_clear(reg_clear),
            .i_push(push[r]), .i_req(req), .i_ac_en(ac_en), .i_tile(tile),
            .i_pop(pop[r]), .o_addr_empty(addr_empty_vec[r]),
            .o_data_empty(data_empty_vec[r]), .o_data(row_data[r])
        );
    end

    row_data_collector collector_inst (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_pop_en(pop_en),
        .i_data_empty_vec(data_empty_vec), .i_addr_empty_vec(addr_empty_vec),
        .i_row_data(row_data), .o_pop(pop), .o_addr_empty(addr_empty),
        .o_data_empty(data_empty), .o_out(o_out)
    );

endmodule

// File: row_data_collector.sv
`timescale 1ns/1ns

module row_data_collector (
    input  logic                                       i_clk,
    input  logic                                       i_nrst,
    input  logic                                       i_pop_en,
    input  logic [input_router_pkg::ROW_COUNT-1:0]     i_data_empty_vec,
    input  logic [input_router_pkg::ROW_COUNT-1:0]     i_addr_empty_vec,
    input  input_router_pkg::out_word_t                i_row_data [input_router_pkg::ROW_COUNT],
    output logic [input_router_pkg::ROW_COUNT-1:0]     o_pop,
    output logic                                       o_addr_empty,
    output logic                                       o_data_empty,
    output input_router_pkg::out_word_t                o_out
);

    logic [input_router_pkg::ROW_ID_WIDTH-1:0] sel;
    logic                                      take;
    logic                                      out_valid;
    logic [input_router_pkg::ROW_ID_WIDTH-1:0] out_row;
    input_router_pkg::coord_t                  out_coord;
    logic [input_router_pkg::DATA_WIDTH-1:0]   out_data;

    assign o_addr_empty = &i_addr_empty_vec;
    assign o_data_empty = &i_data_empty_vec;
    assign take = i_pop_en && !o_data_empty;

    // Lowest non-empty row wins
    always_comb begin
        sel = '0;
        for (int r = input_router_pkg::ROW_COUNT - 1; r >= 0; r--) begin
            if (!i_data_empty_vec[r]) begin
                sel = r[input_router_pkg::ROW_ID_WIDTH-1:0];
            end
        end
        o_pop = '0;
        o_pop[sel] = take;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= take;
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            out_row <= sel;
            out_coord <= i_row_data[sel].coord;
            out_data <= i_row_data[sel].data;
        end
    end

    assign o_out = '{valid: out_valid, row_id: out_row, coord: out_coord, data: out_data};

endmodule

// File: tile_reader.sv
`timescale 1ns/1ns

module tile_reader (
    input  logic                             i_clk,
    input  logic                             i_nrst,
    input  input_router_pkg::mem_write_t     i_mem_wr,
    input  logic                             i_tile_read_en,
    output input_router_pkg::tile_word_t     o_tile
);

    logic [input_router_pkg::DATA_WIDTH-1:0] mem [2**input_router_pkg::ADDR_WIDTH];

    logic [input_router_pkg::ADDR_WIDTH-1:0] scan_ptr;
    logic                                    tile_valid;
    logic [input_router_pkg::ADDR_WIDTH-1:0] tile_addr;
    logic [input_router_pkg::DATA_WIDTH-1:0] tile_data;

    assign o_tile = '{valid: tile_valid, addr: tile_addr, data: tile_data};

    // External load port, used while idle
    always_ff @(posedge i_clk) begin
        if (i_mem_wr.en) begin
            mem[i_mem_wr.addr] <= i_mem_wr.data;
        end
    end

    // Scan pointer wraps and keeps its place across batches
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            scan_ptr <= '0;
            tile_valid <= 1'b0;
        end else begin
            tile_valid <= i_tile_read_en;
            if (i_tile_read_en) begin
                scan_ptr <= scan_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_tile_read_en) begin
            tile_addr <= scan_ptr;
            tile_data <= mem[scan_ptr];
        end
    end

endmodule

// File: row_router.sv
`timescale 1ns/1ns

module row_router (
    input  logic                             i_clk,
    input  logic                             i_nrst,
    input  logic                             i_clear,
    input  logic                             i_push,
    input  input_router_pkg::addr_req_t      i_req,
    input  logic                             i_ac_en,
    input  input_router_pkg::tile_word_t     i_tile,
    input  logic                             i_pop,
    output logic                             o_addr_empty,
    output logic                             o_data_empty,
    output input_router_pkg::out_word_t      o_data
);

    input_router_pkg::addr_req_t addr_q [input_router_pkg::ADDR_DEPTH];
    input_router_pkg::out_word_t data_q [input_router_pkg::ADDR_DEPTH];

    logic [input_router_pkg::QUEUE_PTR_WIDTH-1:0] a_wr, a_rd, d_wr, d_rd;
    logic [input_router_pkg::QUEUE_CNT_WIDTH-1:0] a_cnt, d_cnt;

    logic a_push;
    logic match;
    logic d_pop;
    input_router_pkg::out_word_t cap_word;

    assign o_addr_empty = (a_cnt == '0);
    assign o_data_empty = (d_cnt == '0);
    assign a_push = i_push && (a_cnt != input_router_pkg::ADDR_DEPTH);

    // Only the head request may match the streamed word
    assign match = i_ac_en && i_tile.valid && !o_addr_empty
                   && (i_tile.addr == addr_q[a_rd].addr);
    assign d_pop = i_pop && !o_data_empty;

    always_comb begin
        cap_word = '0;
        cap_word.valid = 1'b1;
        cap_word.coord = addr_q[a_rd].coord;
        cap_word.data = i_tile.data;
    end

    always_comb begin
        o_data = data_q[d_rd];
        o_data.valid = !o_data_empty;
    end

    always_ff @(posedge i_clk) begin
        if (a_push) begin
            addr_q[a_wr] <= i_req;
        end
        if (match) begin
            data_q[d_wr] <= cap_word;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            a_wr <= '0;
            a_rd <= '0;
            a_cnt <= '0;
            d_wr <= '0;
            d_rd <= '0;
            d_cnt <= '0;
        end else if (i_clear) begin
            a_wr <= '0;
            a_rd <= '0;
            a_cnt <= '0;
            d_wr <= '0;
            d_rd <= '0;
            d_cnt <= '0;
        end else begin
            // Address queue
            if (a_push) begin
                a_wr <= (a_wr == input_router_pkg::ADDR_DEPTH - 1) ? '0 : a_wr + 1'b1;
            end
            if (match) begin
                a_rd <= (a_rd == input_router_pkg::ADDR_DEPTH - 1) ? '0 : a_rd + 1'b1;
                d_wr <= (d_wr == input_router_pkg::ADDR_DEPTH - 1) ? '0 : d_wr + 1'b1;
            end
            if (a_push && !match) begin
                a_cnt <= a_cnt + 1'b1;
            end else if (match && !a_push) begin
                a_cnt <= a_cnt - 1'b1;
            end
            // Captured data queue
            if (d_pop) begin
                d_rd <= (d_rd == input_router_pkg::ADDR_DEPTH - 1) ? '0 : d_rd + 1'b1;
            end
            if (match && !d_pop) begin
                d_cnt <= d_cnt + 1'b1;
            end else if (d_pop && !match) begin
                d_cnt <= d_cnt - 1'b1;
            end
        end
    end

endmodule

// File: address_generator.sv
`timescale 1ns/1ns

module address_generator (
    input  logic                                          i_clk,
    input  logic                                          i_nrst,
    input  logic                                          i_ag_en,
    input  input_router_pkg::coord_t                      i_coord,
    input  logic [input_router_pkg::ROW_ID_WIDTH-1:0]     i_row_id,
    input  input_router_pkg::router_cfg_t                 i_cfg,
    output logic [input_router_pkg::ROW_COUNT-1:0]        o_push,
    output input_router_pkg::addr_req_t                   o_req
);

    logic [input_router_pkg::ADDR_WIDTH-1:0] in_width;
    logic [input_router_pkg::ADDR_WIDTH-1:0] addr;
    logic [input_router_pkg::ROW_COUNT-1:0]  push_d;

    // Input rows are o_size * stride pixels wide, sum wraps to the tile
    assign in_width = i_cfg.o_size * i_cfg.stride;
    assign addr = i_cfg.start_addr + i_coord.y * in_width + i_coord.x;

    always_comb begin
        push_d = '0;
        push_d[i_row_id] = i_ag_en;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_push <= '0;
        end else begin
            o_push <= push_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_ag_en) begin
            o_req.coord <= i_coord;
            o_req.addr <= addr;
        end
    end

endmodule

// File: input_router_controller.sv
`timescale 1ns/1ns

module input_router_controller (
    input  logic                                           i_clk,
    input  logic                                           i_nrst,
    input  logic                                           i_en,
    input  logic                                           i_reg_clear,
    input  logic                                           i_data_out_en,
    input  input_router_pkg::router_cfg_t                  i_cfg,
    input  logic                                           i_addr_empty,
    input  logic                                           i_data_empty,
    output input_router_pkg::coord_t                       o_coord,
    output logic [input_router_pkg::ROW_ID_WIDTH-1:0]      o_row_id,
    output logic                                           o_ag_en,
    output logic                                           o_ac_en,
    output logic                                           o_tile_read_en,
    output logic                                           o_pop_en,
    output logic                                           o_done,
    output logic                                           o_reg_clear,
    output logic                                           o_data_out_ready
);

    typedef enum logic [2:0] {
        IDLE,
        INIT,
        COORD_GEN,
        WRITE_STALL,
        TILE_CMP,
        DATA_OUT_STALL,
        DATA_OUT
    } state_t;

    state_t state;

    logic [input_router_pkg::ADDR_WIDTH-1:0] span;
    logic y_step;
    logic x_step;
    logic last_coord;
    logic last_issued;

    // Largest coordinate reached on either axis
    assign span = i_cfg.o_size * i_cfg.stride - i_cfg.stride;
    assign y_step = o_coord.y < span;
    assign x_step = o_coord.x < span;
    assign last_coord = !y_step && !x_step;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= IDLE;
            o_coord <= '0;
            o_row_id <= '0;
            o_ag_en <= 1'b0;
            o_ac_en <= 1'b0;
            o_tile_read_en <= 1'b0;
            o_pop_en <= 1'b0;
            o_done <= 1'b0;
            o_reg_clear <= 1'b0;
            o_data_out_ready <= 1'b0;
            last_issued <= 1'b0;
        end else if (i_reg_clear) begin
            state <= IDLE;
            o_coord <= '0;
            o_row_id <= '0;
            o_ag_en <= 1'b0;
            o_ac_en <= 1'b0;
            o_tile_read_en <= 1'b0;
            o_pop_en <= 1'b0;
            o_done <= 1'b0;
            // Queues follow one cycle later
            o_reg_clear <= 1'b1;
            o_data_out_ready <= 1'b0;
            last_issued <= 1'b0;
        end else begin
            o_reg_clear <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_en && !o_done) begin
                        state <= INIT;
                    end
                end
                INIT: begin
                    o_ag_en <= 1'b1;
                    state <= COORD_GEN;
                end
                COORD_GEN: begin
                    // y is the inner loop
                    if (y_step) begin
                        o_coord.y <= o_coord.y + i_cfg.stride;
                    end else begin
                        o_coord.y <= '0;
                        o_coord.x <= x_step ? o_coord.x + i_cfg.stride : '0;
                    end
                    if (last_coord) begin
                        last_issued <= 1'b1;
                    end
                    // Batch closes at the last row or the last coordinate
                    if (o_row_id == input_router_pkg::ROW_COUNT - 1 || last_coord) begin
                        o_row_id <= '0;
                        o_ag_en <= 1'b0;
                        state <= WRITE_STALL;
                    end else begin
                        o_row_id <= o_row_id + 1'b1;
                    end
                end
                WRITE_STALL: begin
                    // Last registered request lands in its queue here
                    state <= TILE_CMP;
                end
                TILE_CMP: begin
                    if (i_addr_empty) begin
                        o_tile_read_en <= 1'b0;
                        o_ac_en <= 1'b0;
                        o_data_out_ready <= 1'b1;
                        state <= DATA_OUT_STALL;
                    end else begin
                        o_tile_read_en <= 1'b1;
                        o_ac_en <= 1'b1;
                    end
                end
                DATA_OUT_STALL: begin
                    // Hold until the upper level takes the batch
                    if (i_data_out_en) begin
                        state <= DATA_OUT;
                    end
                end
                DATA_OUT: begin
                    if (i_data_empty) begin
                        o_pop_en <= 1'b0;
                        o_reg_clear <= 1'b1;
                        o_data_out_ready <= 1'b0;
                        if (last_issued) begin
                            o_done <= 1'b1;
                            state <= IDLE;
                        end else begin
                            state <= INIT;
                        end
                    end else begin
                        o_pop_en <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: input_router_pkg.sv
package input_router_pkg;

    // Router sizes
    localparam int ROW_COUNT = 4;
    localparam int ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 16;
    localparam int ROW_ID_WIDTH = $clog2(ROW_COUNT);
    localparam int ADDR_DEPTH = 2;

    // Queue pointer and fill count widths inside a row router
    localparam int QUEUE_PTR_WIDTH = (ADDR_DEPTH > 1) ? $clog2(ADDR_DEPTH) : 1;
    localparam int QUEUE_CNT_WIDTH = $clog2(ADDR_DEPTH + 1);

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] x;
        logic [ADDR_WIDTH-1:0] y;
    } coord_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] start_addr;
        logic [ADDR_WIDTH-1:0] o_size;
        logic [ADDR_WIDTH-1:0] stride;
    } router_cfg_t;

    // Pending request held in a row router address queue
    typedef struct packed {
        coord_t                coord;
        logic [ADDR_WIDTH-1:0] addr;
    } addr_req_t;

    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } tile_word_t;

    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } mem_write_t;

    typedef struct packed {
        logic                    valid;
        logic [ROW_ID_WIDTH-1:0] row_id;
        coord_t                  coord;
        logic [DATA_WIDTH-1:0]   data;
    } out_word_t;

endpackage
